//--- include/tpu_settings.svh
// array geometry and data widths; the tile walk and skew depths in the RTL assume TPU_DIM of 4
`ifndef TPU_SETTINGS_SVH
`define TPU_SETTINGS_SVH

// side of the square PE grid
`define TPU_DIM 4

// unsigned operand width
`define TPU_OPW 8

// result width, wide enough for 255 terms of 255*255
`define TPU_ACCW 32

// width of M, N and K, each 1 to 255
`define TPU_SIZEW 8

// A, B and C memory index width
`define TPU_IDXW 16

`endif

//--- hdl/tpu_pkg.sv
// shared data types; lane 0 always sits in the most significant slice of a word
`include "tpu_settings.svh"

package tpu_pkg;

    // one unsigned matrix element
    typedef logic [`TPU_OPW-1:0] operand_t;

    // one A column or B row slice of a block, lane 0 in the top byte
    typedef operand_t [0:`TPU_DIM-1] lane_word_t;

    // one output sum
    typedef logic [`TPU_ACCW-1:0] acc_t;

    // one C row of a tile, lane 0 holds the lowest column
    typedef acc_t [0:`TPU_DIM-1] row_word_t;

    typedef logic [`TPU_SIZEW-1:0] size_t;   // M, N or K
    typedef logic [`TPU_IDXW-1:0]  index_t;  // memory word index

endpackage

//--- hdl/mac_cell.sv
// clear restarts the sum one cycle later, so inputs must be zero in the clear cycle itself
module mac_cell (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clear,
    input  tpu_pkg::operand_t a_in,
    input  tpu_pkg::operand_t b_in,
    output tpu_pkg::operand_t a_out,
    output tpu_pkg::operand_t b_out,
    output tpu_pkg::acc_t     acc
);

    logic          clear_q;
    tpu_pkg::acc_t prod;

    assign prod = tpu_pkg::acc_t'(a_in) * tpu_pkg::acc_t'(b_in);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clear_q <= 1'b0;
            a_out   <= '0;
            b_out   <= '0;
            acc     <= '0;
        end else begin
            clear_q <= clear;
            a_out   <= a_in;   // to the right neighbor
            b_out   <= b_in;   // to the cell below
            acc     <= clear_q ? prod : acc + prod;
        end
    end

endmodule

//--- hdl/systolic_array.sv
// output-stationary grid; row r of A enters from the left, column c of B from the top
`include "tpu_settings.svh"

module systolic_array (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clear,
    input  tpu_pkg::operand_t   a_edge [`TPU_DIM],
    input  tpu_pkg::operand_t   b_edge [`TPU_DIM],
    output tpu_pkg::row_word_t  acc_rows [`TPU_DIM]
);

    tpu_pkg::operand_t a_h [`TPU_DIM][`TPU_DIM+1];  // horizontal links, column 0 is the edge
    tpu_pkg::operand_t b_v [`TPU_DIM+1][`TPU_DIM];  // vertical links, row 0 is the edge
    tpu_pkg::acc_t     acc_grid [`TPU_DIM][`TPU_DIM];

    for (genvar r = 0; r < `TPU_DIM; r++) begin : g_row
        assign a_h[r][0] = a_edge[r];
        assign b_v[0][r] = b_edge[r];

        for (genvar c = 0; c < `TPU_DIM; c++) begin : g_col
            mac_cell u_pe (
                .clk   (clk),
                .rst_n (rst_n),
                .clear (clear),
                .a_in  (a_h[r][c]),
                .b_in  (b_v[r][c]),
                .a_out (a_h[r][c+1]),
                .b_out (b_v[r+1][c]),
                .acc   (acc_grid[r][c])
            );

            assign acc_rows[r][c] = acc_grid[r][c];  // lane c is column c
        end
    end

endmodule

//--- hdl/operand_skew.sv
// memory read data is expected one cycle after fetch_en; idle lanes are driven with zeros
`include "tpu_settings.svh"

module operand_skew (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fetch_en,
    input  tpu_pkg::lane_word_t a_data,
    input  tpu_pkg::lane_word_t b_data,
    output tpu_pkg::operand_t   a_edge [`TPU_DIM],
    output tpu_pkg::operand_t   b_edge [`TPU_DIM]
);

    logic fetch_d;  // read data valid this cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_d <= 1'b0;
        end else begin
            fetch_d <= fetch_en;
        end
    end

    for (genvar i = 0; i < `TPU_DIM; i++) begin : g_lane
        tpu_pkg::operand_t a_q;
        tpu_pkg::operand_t b_q;

        assign a_q = fetch_d ? a_data[i] : '0;
        assign b_q = fetch_d ? b_data[i] : '0;

        if (i == 0) begin : g_direct
            assign a_edge[i] = a_q;  // corner lane enters without delay
            assign b_edge[i] = b_q;
        end else begin : g_delay
            tpu_pkg::operand_t a_sr [i];  // lane i lags by i cycles
            tpu_pkg::operand_t b_sr [i];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int j = 0; j < i; j++) begin
                        a_sr[j] <= '0;
                        b_sr[j] <= '0;
                    end
                end else begin
                    a_sr[0] <= a_q;
                    b_sr[0] <= b_q;
                    for (int j = 1; j < i; j++) begin
                        a_sr[j] <= a_sr[j-1];
                        b_sr[j] <= b_sr[j-1];
                    end
                end
            end

            assign a_edge[i] = a_sr[i-1];
            assign b_edge[i] = b_sr[i-1];
        end
    end

endmodule

//--- hdl/tile_sequencer.sv
// k, m and n must be nonzero at in_valid; job inputs are sampled only while busy is low
`include "tpu_settings.svh"

module tile_sequencer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  tpu_pkg::size_t  k,
    input  tpu_pkg::size_t  m,
    input  tpu_pkg::size_t  n,
    input  logic            drain_busy,
    output logic            busy,
    output tpu_pkg::index_t a_index,
    output tpu_pkg::index_t b_index,
    output logic            fetch_en,
    output logic            capture,
    output tpu_pkg::size_t  tile_mb,
    output tpu_pkg::size_t  tile_nb,
    output tpu_pkg::size_t  m_dim
);

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_FETCH = 3'd1;
    localparam logic [2:0] S_FLUSH = 3'd2;
    localparam logic [2:0] S_CAPT  = 3'd3;
    localparam logic [2:0] S_LAST  = 3'd4;

    logic [2:0]      state;
    tpu_pkg::size_t  cnt;       // k step in fetch, cycle count in flush and last
    tpu_pkg::size_t  k_dim;
    tpu_pkg::size_t  m_blk;     // row blocks after padding
    tpu_pkg::size_t  n_blk;     // column blocks after padding
    tpu_pkg::index_t a_base;    // tile_mb * k_dim
    tpu_pkg::index_t b_base;    // tile_nb * k_dim
    logic            accept;
    logic            last_mb;
    logic            last_tile;

    assign busy      = (state != S_IDLE);
    assign accept    = (state == S_IDLE) && in_valid;
    assign fetch_en  = (state == S_FETCH);
    assign capture   = (state == S_CAPT) && !drain_busy;  // hold off while previous drain runs
    assign a_index   = a_base + tpu_pkg::index_t'(cnt);
    assign b_index   = b_base + tpu_pkg::index_t'(cnt);
    assign last_mb   = (tile_mb == m_blk - 1'b1);
    assign last_tile = last_mb && (tile_nb == n_blk - 1'b1);

    // job sizes, held for the whole job
    always_ff @(posedge clk) begin
        if (accept) begin
            k_dim <= k;
            m_dim <= m;
            m_blk <= tpu_pkg::size_t'((9'(m) + 9'(`TPU_DIM - 1)) / 9'(`TPU_DIM));
            n_blk <= tpu_pkg::size_t'((9'(n) + 9'(`TPU_DIM - 1)) / 9'(`TPU_DIM));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            cnt     <= '0;
            tile_mb <= '0;
            tile_nb <= '0;
            a_base  <= '0;
            b_base  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state   <= S_FETCH;
                        cnt     <= '0;
                        tile_mb <= '0;
                        tile_nb <= '0;
                        a_base  <= '0;
                        b_base  <= '0;
                    end
                end
                S_FETCH: begin
                    if (cnt == k_dim - 1'b1) begin
                        state <= S_FLUSH;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_FLUSH: begin
                    // last operand needs 2*DIM-1 cycles to reach the far corner
                    if (cnt == tpu_pkg::size_t'(2 * `TPU_DIM - 2)) begin
                        state <= S_CAPT;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_CAPT: begin
                    if (capture) begin
                        cnt <= '0;
                        if (last_tile) begin
                            state <= S_LAST;
                        end else if (last_mb) begin   // row blocks run inner
                            state   <= S_FETCH;
                            tile_mb <= '0;
                            a_base  <= '0;
                            tile_nb <= tile_nb + 1'b1;
                            b_base  <= b_base + tpu_pkg::index_t'(k_dim);
                        end else begin
                            state   <= S_FETCH;
                            tile_mb <= tile_mb + 1'b1;
                            a_base  <= a_base + tpu_pkg::index_t'(k_dim);
                        end
                    end
                end
                S_LAST: begin
                    // wait out the final drain, busy drops after its last row
                    if (cnt == tpu_pkg::size_t'(`TPU_DIM - 1)) begin
                        state <= S_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    a_job_sizes: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> (k != '0) && (m != '0) && (n != '0))
        else $error("job accepted with a zero dimension");

endmodule

//--- hdl/result_drain.sv
// one row per cycle for TPU_DIM cycles after capture; rows at or past M are skipped, not written
`include "tpu_settings.svh"

module result_drain (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                capture,
    input  tpu_pkg::row_word_t  acc_rows [`TPU_DIM],
    input  tpu_pkg::size_t      tile_mb,
    input  tpu_pkg::size_t      tile_nb,
    input  tpu_pkg::size_t      m_dim,
    output logic                drain_busy,
    output logic                c_wr_en,
    output tpu_pkg::index_t     c_index,
    output tpu_pkg::row_word_t  c_data
);

    localparam int ROWW = $clog2(`TPU_DIM);

    tpu_pkg::row_word_t hold [`TPU_DIM];  // finished tile, frees the array for the next one
    tpu_pkg::index_t    c_base;           // C index of row 0
    tpu_pkg::size_t     m_q;
    logic [9:0]         row_base;         // matrix row of tile row 0
    logic [9:0]         cur_row;
    logic [ROWW-1:0]    row;

    assign cur_row = row_base + 10'(row);
    assign c_wr_en = drain_busy && (cur_row < 10'(m_q));
    assign c_index = c_base + tpu_pkg::index_t'(row);
    assign c_data  = hold[row];

    always_ff @(posedge clk) begin
        if (capture) begin
            for (int r = 0; r < `TPU_DIM; r++) begin
                hold[r] <= acc_rows[r];
            end
            // C is stored column block by column block, each block M rows tall
            c_base   <= tpu_pkg::index_t'(tpu_pkg::index_t'(tile_nb) * tpu_pkg::index_t'(m_dim)
                        + tpu_pkg::index_t'(tile_mb) * tpu_pkg::index_t'(`TPU_DIM));
            row_base <= 10'(tile_mb) * 10'(`TPU_DIM);
            m_q      <= m_dim;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drain_busy <= 1'b0;
            row        <= '0;
        end else if (capture) begin
            drain_busy <= 1'b1;
            row        <= '0;
        end else if (drain_busy) begin
            row <= row + 1'b1;
            if (row == ROWW'(`TPU_DIM - 1)) begin
                drain_busy <= 1'b0;  // fixed length even when rows are skipped
            end
        end
    end

    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        capture |-> !drain_busy)
        else $error("tile captured before the previous drain finished");

    // the sequencer must hold m_dim steady for the whole job
    a_row_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        c_wr_en |-> (cur_row < 10'(m_dim)))
        else $error("C write for a row at or beyond M");

endmodule

//--- hdl/tpu.sv
// A and B are read-only synchronous memories with one cycle of read latency; C always accepts
`include "tpu_settings.svh"

module tpu (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  tpu_pkg::size_t      k,
    input  tpu_pkg::size_t      m,
    input  tpu_pkg::size_t      n,
    output logic                busy,
    output tpu_pkg::index_t     a_index,
    input  tpu_pkg::lane_word_t a_data,
    output tpu_pkg::index_t     b_index,
    input  tpu_pkg::lane_word_t b_data,
    output logic                c_wr_en,
    output tpu_pkg::index_t     c_index,
    output tpu_pkg::row_word_t  c_data
);

    logic               fetch_en;
    logic               capture;   // also clears the array accumulators
    logic               drain_busy;
    tpu_pkg::size_t     tile_mb;
    tpu_pkg::size_t     tile_nb;
    tpu_pkg::size_t     m_dim;
    tpu_pkg::operand_t  a_edge [`TPU_DIM];
    tpu_pkg::operand_t  b_edge [`TPU_DIM];
    tpu_pkg::row_word_t acc_rows [`TPU_DIM];

    tile_sequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .k          (k),
        .m          (m),
        .n          (n),
        .drain_busy (drain_busy),
        .busy       (busy),
        .a_index    (a_index),
        .b_index    (b_index),
        .fetch_en   (fetch_en),
        .capture    (capture),
        .tile_mb    (tile_mb),
        .tile_nb    (tile_nb),
        .m_dim      (m_dim)
    );

    operand_skew u_skew (
        .clk      (clk),
        .rst_n    (rst_n),
        .fetch_en (fetch_en),
        .a_data   (a_data),
        .b_data   (b_data),
        .a_edge   (a_edge),
        .b_edge   (b_edge)
    );

    systolic_array u_array (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (capture),
        .a_edge   (a_edge),
        .b_edge   (b_edge),
        .acc_rows (acc_rows)
    );

    result_drain u_drain (
        .clk        (clk),
        .rst_n      (rst_n),
        .capture    (capture),
        .acc_rows   (acc_rows),
        .tile_mb    (tile_mb),
        .tile_nb    (tile_nb),
        .m_dim      (m_dim),
        .drain_busy (drain_busy),
        .c_wr_en    (c_wr_en),
        .c_index    (c_index),
        .c_data     (c_data)
    );

endmodule

//--- sim/tb_tpu.sv
// drives inputs on the falling clock edge; A, B and C are modelled as 256-word memories
`include "tpu_settings.svh"

module tb_tpu;

    localparam int DIM  = `TPU_DIM;
    localparam int MAXD = 12;   // largest padded dimension in the tests
    localparam int MEMD = 256;
    // tiles times (K plus 15) for each job in run order, plus slack
    localparam int CYCLE_LIMIT = 1 * (4 + 15) + 1 * (1 + 15) + 4 * (3 + 15) + 6 * (7 + 15)
                               + 4 * (5 + 15) + 2 * (2 + 15) + 200;

    logic                clk;
    logic                rst_n;
    logic                in_valid;
    tpu_pkg::size_t      k;
    tpu_pkg::size_t      m;
    tpu_pkg::size_t      n;
    logic                busy;
    tpu_pkg::index_t     a_index;
    tpu_pkg::index_t     b_index;
    tpu_pkg::lane_word_t a_data = '0;
    tpu_pkg::lane_word_t b_data = '0;
    logic                c_wr_en;
    tpu_pkg::index_t     c_index;
    tpu_pkg::row_word_t  c_data;

    tpu_pkg::lane_word_t a_mem [MEMD];
    tpu_pkg::lane_word_t b_mem [MEMD];
    tpu_pkg::row_word_t  c_mem [MEMD];
    int                  c_hits [MEMD];         // writes seen per C index
    tpu_pkg::operand_t   mat_a [MAXD][MAXD];    // A[row][k]
    tpu_pkg::operand_t   mat_b [MAXD][MAXD];    // B[k][col]
    logic [31:0]         lcg_state = 32'd95090;
    int                  cycle_count = 0;

    tpu u_tpu (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .k        (k),
        .m        (m),
        .n        (n),
        .busy     (busy),
        .a_index  (a_index),
        .a_data   (a_data),
        .b_index  (b_index),
        .b_data   (b_data),
        .c_wr_en  (c_wr_en),
        .c_index  (c_index),
        .c_data   (c_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        a_data <= a_mem[a_index[7:0]];  // one cycle read latency
        b_data <= b_mem[b_index[7:0]];
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("simulation ran past %0d cycles without finishing", CYCLE_LIMIT);
            abort_run();
        end else if (c_wr_en && c_index >= MEMD) begin
            $display("C write to index %0d outside the result memory", c_index);
            abort_run();
        end else if (c_wr_en) begin
            c_mem[c_index[7:0]]  = c_data;
            c_hits[c_index[7:0]] = c_hits[c_index[7:0]] + 1;
        end
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("Fail at time %0t: %s got 0x%0h, expected 0x%0h", $time, what, got, expected);
            abort_run();
        end
    endtask

    function automatic tpu_pkg::operand_t rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:24];  // upper bits have the longest period
    endfunction

    function automatic logic [31:0] dot(input int row, input int col, input int kk);
        logic [31:0] sum;
        sum = '0;
        for (int s = 0; s < kk; s++) begin
            sum += 32'(mat_a[row][s]) * 32'(mat_b[s][col]);
        end
        return sum;
    endfunction

    task automatic fill_random(input int mm, input int nn, input int kk);
        for (int s = 0; s < kk; s++) begin
            for (int i = 0; i < mm; i++) begin
                mat_a[i][s] = rand_byte();
            end
            for (int j = 0; j < nn; j++) begin
                mat_b[s][j] = rand_byte();
            end
        end
    endtask

    // block words with zero lanes past M or N
    task automatic load_memories(input int mm, input int nn, input int kk);
        for (int w = 0; w < MEMD; w++) begin
            a_mem[w]  = '0;
            b_mem[w]  = '0;
            c_hits[w] = 0;
        end
        for (int blk = 0; blk < MAXD / DIM; blk++) begin
            for (int s = 0; s < kk; s++) begin
                for (int i = 0; i < DIM; i++) begin
                    a_mem[blk * kk + s][i] = (blk * DIM + i < mm) ? mat_a[blk * DIM + i][s] : '0;
                    b_mem[blk * kk + s][i] = (blk * DIM + i < nn) ? mat_b[s][blk * DIM + i] : '0;
                end
            end
        end
    endtask

    task automatic compare_with_golden(input int mm, input int nn, input int kk);
        int nblk;
        int idx;
        int col;
        int total;
        nblk  = (nn + DIM - 1) / DIM;
        total = 0;
        for (int w = 0; w < MEMD; w++) begin
            total += c_hits[w];
        end
        if (total != nblk * mm) begin
            $display("saw %0d C row writes where %0d were due", total, nblk * mm);
            abort_run();
        end
        for (int nb = 0; nb < nblk; nb++) begin
            for (int row = 0; row < mm; row++) begin
                idx = nb * mm + row;
                if (c_hits[idx] != 1) begin
                    $display("C index %0d written %0d times instead of once", idx, c_hits[idx]);
                    abort_run();
                end
                for (int c = 0; c < DIM; c++) begin
                    col = nb * DIM + c;
                    check_equal(c_mem[idx][c], (col < nn) ? dot(row, col, kk) : 32'd0,
                                $sformatf("C[%0d][%0d] at index %0d", row, col, idx));
                end
            end
        end
    endtask

    task automatic run_job(input int mm, input int nn, input int kk, input bit poke);
        load_memories(mm, nn, kk);
        in_valid = 1'b1;
        k        = 8'(kk);
        m        = 8'(mm);
        n        = 8'(nn);
        @(negedge clk);
        in_valid = 1'b0;
        check_equal(32'(busy), 32'd1, "busy after in_valid");
        if (poke) begin
            repeat (3) @(negedge clk);
            in_valid = 1'b1;    // different sizes, must be ignored
            k        = 8'd1;
            m        = 8'd1;
            n        = 8'd1;
            @(negedge clk);
            in_valid = 1'b0;
        end
        while (busy) begin
            @(negedge clk);
        end
        compare_with_golden(mm, nn, kk);
    endtask

    task automatic idle_after_reset();
        repeat (4) begin
            @(negedge clk);
            check_equal(32'(busy), 32'd0, "busy before any job");
            check_equal(32'(c_wr_en), 32'd0, "c_wr_en before any job");
        end
    endtask

    task automatic hand_values_job();
        for (int i = 0; i < DIM; i++) begin
            for (int s = 0; s < DIM; s++) begin
                mat_a[i][s] = 8'(i * 16 + s * 3 + 1);
                mat_b[s][i] = 8'(200 - i * 7 - s * 11);
            end
        end
        for (int s = 0; s < DIM; s++) begin
            mat_a[0][s] = 8'd255;   // C[0][0] sums four 255 * 255 terms
            mat_b[s][0] = 8'd255;
        end
        run_job(4, 4, 4, 1'b0);
    endtask

    task automatic outer_product_job();
        for (int i = 0; i < DIM; i++) begin
            mat_a[i][0] = 8'(17 * i + 3);
            mat_b[0][i] = 8'(251 - 40 * i);
        end
        run_job(4, 4, 1, 1'b0);
    endtask

    task automatic ragged_edges_job();
        fill_random(5, 6, 3);
        run_job(5, 6, 3, 1'b0);
    endtask

    task automatic multi_tile_job();
        fill_random(9, 8, 7);
        run_job(9, 8, 7, 1'b0);
    endtask

    task automatic ignore_and_restart();
        fill_random(6, 5, 5);
        run_job(6, 5, 5, 1'b1);
        fill_random(3, 7, 2);
        run_job(3, 7, 2, 1'b0);   // starts on the edge where busy is seen low
    endtask

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        k        = '0;
        m        = '0;
        n        = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        idle_after_reset();
        hand_values_job();
        outer_product_job();
        ragged_edges_job();
        multi_tile_job();
        ignore_and_restart();
        $display("Test passed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+include
hdl/tpu_pkg.sv
hdl/mac_cell.sv
hdl/systolic_array.sv
hdl/operand_skew.sv
hdl/tile_sequencer.sv
hdl/result_drain.sv
hdl/tpu.sv
sim/tb_tpu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_tpu -f sim.f -o tb_tpu_sim
./obj_dir/tb_tpu_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
